/* logic/id_macros.svh */
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Data path width
`define XLEN 32

// Register file addressing
`define REG_ADDR_W 5
`define REG_COUNT 32

`endif

/* logic/isa_pkg.sv */
`include "id_macros.svh"

package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    // ALU funct3, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        opcode_e                opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } u_fmt_t;

    // One instruction word, viewed by format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_t;

endpackage

/* logic/pipe_pkg.sv */
`include "id_macros.svh"

package pipe_pkg;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_NOP, RES_ARITH, RES_LOGIC, RES_SHIFT, RES_LD_ST
    } res_sel_e;

    typedef struct packed {
        alu_op_e                alu_op;
        res_sel_e               res_sel;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
        logic                   rs1_re;
        logic                   rs2_re;
        logic                   use_imm; // op_b from imm
        logic [`XLEN-1:0]       imm;
    } dec_t;

    typedef struct packed {
        logic                   valid;
        logic                   is_load;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } fwd_src_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        res_sel_e               res_sel;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
        logic [`XLEN-1:0]       op_a;
        logic [`XLEN-1:0]       op_b;
        logic [`XLEN-1:0]       imm; // Store offset
    } id_ex_t;

endpackage

/* logic/inst_decoder.sv */
`timescale 1ns/100ps
`include "id_macros.svh"

module inst_decoder (
    input  isa_pkg::inst_t inst,
    output pipe_pkg::dec_t dec
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] shamt;

    assign imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_u = {inst.u.imm, 12'h000};
    assign shamt = {{(`XLEN-`REG_ADDR_W){1'b0}}, inst.r.rs2}; // Shamt sits in rs2 slot

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_NOP;
        case (inst.r.opcode)
            OPC_OP: begin
                case ({inst.r.funct7, inst.r.funct3})
                    {F7_BASE, F3_ADD_SUB}: dec.alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD_SUB}:  dec.alu_op = ALU_SUB;
                    {F7_BASE, F3_XOR}:     dec.alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:      dec.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     dec.alu_op = ALU_AND;
                    {F7_BASE, F3_SLL}:     dec.alu_op = ALU_SLL;
                    {F7_BASE, F3_SRL_SRA}: dec.alu_op = ALU_SRL;
                    {F7_ALT, F3_SRL_SRA}:  dec.alu_op = ALU_SRA;
                    {F7_BASE, F3_SLT}:     dec.alu_op = ALU_SLT;
                    {F7_BASE, F3_SLTU}:    dec.alu_op = ALU_SLTU;
                    default: ;
                endcase
                if (dec.alu_op != ALU_NOP) begin
                    dec.rd     = inst.r.rd;
                    dec.rd_we  = 1'b1;
                    dec.rs1_re = 1'b1;
                    dec.rs2_re = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                case (inst.i.funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_SLL: begin
                        if (inst.r.funct7 == F7_BASE) dec.alu_op = ALU_SLL;
                    end
                    F3_SRL_SRA: begin
                        if (inst.r.funct7 == F7_BASE) dec.alu_op = ALU_SRL;
                        else if (inst.r.funct7 == F7_ALT) dec.alu_op = ALU_SRA;
                    end
                    default: ;
                endcase
                if (dec.alu_op != ALU_NOP) begin
                    dec.rd      = inst.i.rd;
                    dec.rd_we   = 1'b1;
                    dec.rs1_re  = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.imm     = (inst.i.funct3 == F3_SLL ||
                                   inst.i.funct3 == F3_SRL_SRA) ? shamt : imm_i;
                end
            end
            OPC_LUI: begin
                dec.alu_op  = ALU_OR; // 0 | imm
                dec.rd      = inst.u.rd;
                dec.rd_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
            end
            OPC_LOAD: begin
                case (inst.i.funct3)
                    F3_LB:   dec.alu_op = ALU_LB;
                    F3_LH:   dec.alu_op = ALU_LH;
                    F3_LW:   dec.alu_op = ALU_LW;
                    F3_LBU:  dec.alu_op = ALU_LBU;
                    F3_LHU:  dec.alu_op = ALU_LHU;
                    default: ;
                endcase
                if (dec.alu_op != ALU_NOP) begin
                    dec.rd     = inst.i.rd;
                    dec.rd_we  = 1'b1;
                    dec.rs1_re = 1'b1;
                    dec.imm    = imm_i;
                end
            end
            OPC_STORE: begin
                case (inst.s.funct3)
                    F3_SB:   dec.alu_op = ALU_SB;
                    F3_SH:   dec.alu_op = ALU_SH;
                    F3_SW:   dec.alu_op = ALU_SW;
                    default: ;
                endcase
                if (dec.alu_op != ALU_NOP) begin
                    dec.rs1_re = 1'b1;
                    dec.rs2_re = 1'b1; // Store data
                    dec.imm    = imm_s;
                end
            end
            default: ;
        endcase

        // Result class follows from the operation
        case (dec.alu_op)
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU: dec.res_sel = RES_ARITH;
            ALU_XOR, ALU_OR, ALU_AND:           dec.res_sel = RES_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:          dec.res_sel = RES_SHIFT;
            ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
            ALU_SB, ALU_SH, ALU_SW:             dec.res_sel = RES_LD_ST;
            default:                            dec.res_sel = RES_NOP;
        endcase
    end

endmodule

/* logic/operand_forward.sv */
`timescale 1ns/100ps
`include "id_macros.svh"

module operand_forward (
    input  logic [`REG_ADDR_W-1:0] addr,
    input  logic                   re,
    input  logic [`XLEN-1:0]       rf_data,
    input  pipe_pkg::fwd_src_t     ex_fwd,
    input  pipe_pkg::fwd_src_t     mem_fwd,
    output logic [`XLEN-1:0]       value,
    output logic                   hazard
);
    import pipe_pkg::*;

    logic live;
    logic ex_hit;
    logic mem_hit;

    assign live    = re && (addr != '0); // x0 never forwards
    assign ex_hit  = live && ex_fwd.valid && (ex_fwd.rd == addr);
    assign mem_hit = live && mem_fwd.valid && (mem_fwd.rd == addr);

    always_comb begin
        hazard = 1'b0;
        value  = '0;
        if (ex_hit && ex_fwd.is_load) begin
            hazard = 1'b1; // Load data not ready yet
        end else if (ex_hit) begin
            value = ex_fwd.data;
        end else if (mem_hit) begin
            value = mem_fwd.data;
        end else if (re) begin
            value = rf_data;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/100ps
`include "id_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  pipe_pkg::wb_t          wb,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Old value on same-cycle write
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* logic/id_ex_reg.sv */
`timescale 1ns/100ps
`include "id_macros.svh"

module id_ex_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  pipe_pkg::dec_t   dec,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] rs2_val,
    input  logic             rs1_hazard,
    input  logic             rs2_hazard,
    output logic             stall,
    output pipe_pkg::id_ex_t id_ex
);
    import pipe_pkg::*;

    id_ex_t nxt;

    assign stall = rs1_hazard | rs2_hazard;

    always_comb begin
        nxt.valid   = 1'b1;
        nxt.alu_op  = dec.alu_op;
        nxt.res_sel = dec.res_sel;
        nxt.rd      = dec.rd;
        nxt.rd_we   = dec.rd_we;
        nxt.op_a    = rs1_val;
        nxt.op_b    = dec.use_imm ? dec.imm : rs2_val;
        nxt.imm     = dec.imm;
    end

    always_ff @(posedge clk) begin
        if (rst || stall || !in_valid) begin
            id_ex.valid   <= 1'b0; // Bubble
            id_ex.rd_we   <= 1'b0;
            id_ex.alu_op  <= ALU_NOP;
            id_ex.res_sel <= RES_NOP;
        end else begin
            id_ex <= nxt;
        end
    end

endmodule

/* logic/id_stage.sv */
`timescale 1ns/100ps
`include "id_macros.svh"

module id_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  isa_pkg::inst_t     inst,
    input  pipe_pkg::fwd_src_t ex_fwd,
    input  pipe_pkg::fwd_src_t mem_fwd,
    input  pipe_pkg::wb_t      wb,
    output logic               stall,
    output pipe_pkg::id_ex_t   id_ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    dec_t             dec;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             rs1_hazard;
    logic             rs2_hazard;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .rs1_addr (inst.r.rs1),
        .rs2_addr (inst.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    operand_forward u_fwd_rs1 (
        .addr    (inst.r.rs1),
        .re      (dec.rs1_re),
        .rf_data (rs1_data),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .value   (rs1_val),
        .hazard  (rs1_hazard)
    );

    operand_forward u_fwd_rs2 (
        .addr    (inst.r.rs2),
        .re      (dec.rs2_re),
        .rf_data (rs2_data),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .value   (rs2_val),
        .hazard  (rs2_hazard)
    );

    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rs1_hazard (rs1_hazard),
        .rs2_hazard (rs2_hazard),
        .stall      (stall),
        .id_ex      (id_ex)
    );

endmodule

/* bench/tb_id_stage.sv */
`timescale 1ns/100ps
`include "id_macros.svh"

module tb_id_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        logic [`XLEN-1:0]       inst;
        logic                   in_valid;
        fwd_src_t               ex;
        fwd_src_t               mem;
        logic                   stall;
        logic                   valid;
        alu_op_e                alu_op;
        res_sel_e               res_sel;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
        logic [`XLEN:0]         op_a; // Top bit set means model register
        logic [`XLEN:0]         op_b;
        logic [`XLEN-1:0]       imm;
    } vec_t;

    localparam fwd_src_t NO_FWD  = '0;
    localparam int       TIMEOUT = 100;

    logic     clk;
    logic     rst;
    logic     in_valid;
    inst_t    inst;
    fwd_src_t ex_fwd;
    fwd_src_t mem_fwd;
    wb_t      wb;
    logic     stall;
    id_ex_t   id_ex;

    logic [`XLEN-1:0] model [`REG_COUNT];
    vec_t             vecs [$];
    integer           seed;
    int               row_idx;

    id_stage u_dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .inst     (inst),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .wb       (wb),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL time=%0t row=%0d signal=%s expected=%h actual=%h",
                     $time, row_idx, name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic [32:0] reg_ref(input logic [4:0] idx);
        return {1'b1, 27'd0, idx};
    endfunction

    function automatic logic [32:0] lit_val(input logic [31:0] val);
        return {1'b0, val};
    endfunction

    function automatic logic [31:0] resolve_operand(input logic [32:0] o);
        return o[32] ? model[o[4:0]] : o[31:0];
    endfunction

    function automatic fwd_src_t fwd_hit(input logic ld, input logic [4:0] rd,
                                         input logic [31:0] data);
        return {1'b1, ld, rd, data};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input opcode_e opc, input logic [2:0] f3,
                                           input logic [11:0] imm, input logic [4:0] rd,
                                           input logic [4:0] rs1);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic push_vector(input logic [31:0] w, input logic iv, input fwd_src_t ex,
                               input fwd_src_t mem, input logic st, input logic v,
                               input alu_op_e op, input res_sel_e rs, input logic [4:0] rd,
                               input logic we, input logic [32:0] a, input logic [32:0] b,
                               input logic [31:0] imm);
        vec_t t;
        t = {w, iv, ex, mem, st, v, op, rs, rd, we, a, b, imm};
        vecs.push_back(t);
    endtask

    task automatic plain_vector(input logic [31:0] w, input alu_op_e op, input res_sel_e rs,
                                input logic [4:0] rd, input logic we, input logic [32:0] a,
                                input logic [32:0] b, input logic [31:0] imm);
        push_vector(w, 1'b1, NO_FWD, NO_FWD, 1'b0, 1'b1, op, rs, rd, we, a, b, imm);
    endtask

    task automatic bubble_vector(input logic [31:0] w, input logic iv, input fwd_src_t ex,
                                 input logic st);
        push_vector(w, iv, ex, NO_FWD, st, 1'b0, ALU_NOP, RES_NOP, 5'd0, 1'b0,
                    lit_val(32'h0), lit_val(32'h0), 32'h0);
    endtask

    task automatic fwd_vector(input logic [4:0] rd, input logic [4:0] rs1, input fwd_src_t ex,
                              input fwd_src_t mem, input logic [32:0] a);
        push_vector(r_word(F7_BASE, F3_ADD_SUB, rd, rs1, 5'd2), 1'b1, ex, mem, 1'b0, 1'b1,
                    ALU_ADD, RES_ARITH, rd, 1'b1, a, reg_ref(5'd2), 32'h0);
    endtask

    task automatic rr_vector(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2, input alu_op_e op,
                             input res_sel_e rs);
        plain_vector(r_word(f7, f3, rd, rs1, rs2), op, rs, rd, 1'b1, reg_ref(rs1),
                     reg_ref(rs2), 32'h0);
    endtask

    task automatic imm_vector(input logic [2:0] f3, input logic [11:0] imm,
                              input logic [4:0] rd, input logic [4:0] rs1, input alu_op_e op,
                              input res_sel_e rs, input logic [31:0] exp);
        plain_vector(i_word(OPC_OP_IMM, f3, imm, rd, rs1), op, rs, rd, 1'b1, reg_ref(rs1),
                     lit_val(exp), exp);
    endtask

    task automatic ld_vector(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                             input logic [4:0] rs1, input alu_op_e op, input logic [31:0] exp);
        plain_vector(i_word(OPC_LOAD, f3, imm, rd, rs1), op, RES_LD_ST, rd, 1'b1,
                     reg_ref(rs1), lit_val(32'h0), exp); // rs2 not read
    endtask

    task automatic st_vector(input logic [2:0] f3, input logic [11:0] imm,
                             input logic [4:0] rs1, input logic [4:0] rs2, input alu_op_e op,
                             input logic [31:0] exp);
        plain_vector(s_word(f3, imm, rs1, rs2), op, RES_LD_ST, 5'd0, 1'b0, reg_ref(rs1),
                     reg_ref(rs2), exp);
    endtask

    task automatic build_table();
        rr_vector(F7_BASE, F3_ADD_SUB, 5'd8, 5'd1, 5'd2, ALU_ADD, RES_ARITH);
        rr_vector(F7_ALT, F3_ADD_SUB, 5'd9, 5'd3, 5'd4, ALU_SUB, RES_ARITH);
        rr_vector(F7_BASE, F3_XOR, 5'd10, 5'd5, 5'd6, ALU_XOR, RES_LOGIC);
        rr_vector(F7_BASE, F3_OR, 5'd11, 5'd7, 5'd1, ALU_OR, RES_LOGIC);
        rr_vector(F7_BASE, F3_AND, 5'd12, 5'd2, 5'd3, ALU_AND, RES_LOGIC);
        rr_vector(F7_BASE, F3_SLL, 5'd13, 5'd4, 5'd5, ALU_SLL, RES_SHIFT);
        rr_vector(F7_BASE, F3_SRL_SRA, 5'd14, 5'd6, 5'd7, ALU_SRL, RES_SHIFT);
        rr_vector(F7_ALT, F3_SRL_SRA, 5'd15, 5'd1, 5'd3, ALU_SRA, RES_SHIFT);
        rr_vector(F7_BASE, F3_SLT, 5'd16, 5'd5, 5'd7, ALU_SLT, RES_ARITH);
        rr_vector(F7_BASE, F3_SLTU, 5'd17, 5'd2, 5'd6, ALU_SLTU, RES_ARITH);
        imm_vector(F3_ADD_SUB, 12'hffb, 5'd9, 5'd3, ALU_ADD, RES_ARITH, 32'hffff_fffb);
        imm_vector(F3_XOR, 12'h7ff, 5'd10, 5'd4, ALU_XOR, RES_LOGIC, 32'h0000_07ff);
        imm_vector(F3_OR, 12'h800, 5'd11, 5'd5, ALU_OR, RES_LOGIC, 32'hffff_f800);
        imm_vector(F3_AND, 12'h0f0, 5'd12, 5'd6, ALU_AND, RES_LOGIC, 32'h0000_00f0);
        imm_vector(F3_SLT, 12'hfff, 5'd13, 5'd7, ALU_SLT, RES_ARITH, 32'hffff_ffff);
        imm_vector(F3_SLTU, 12'h001, 5'd14, 5'd1, ALU_SLTU, RES_ARITH, 32'h0000_0001);
        imm_vector(F3_SLL, 12'h01f, 5'd15, 5'd2, ALU_SLL, RES_SHIFT, 32'h0000_001f);
        imm_vector(F3_SRL_SRA, 12'h004, 5'd16, 5'd3, ALU_SRL, RES_SHIFT, 32'h0000_0004);
        imm_vector(F3_SRL_SRA, 12'h411, 5'd17, 5'd4, ALU_SRA, RES_SHIFT, 32'h0000_0011);
        plain_vector(u_word(20'habcde, 5'd18), ALU_OR, RES_LOGIC, 5'd18, 1'b1,
                     lit_val(32'h0), lit_val(32'habcd_e000), 32'habcd_e000);
        ld_vector(F3_LB, 12'hfff, 5'd19, 5'd1, ALU_LB, 32'hffff_ffff);
        ld_vector(F3_LH, 12'h7fe, 5'd20, 5'd2, ALU_LH, 32'h0000_07fe);
        ld_vector(F3_LW, 12'h800, 5'd21, 5'd3, ALU_LW, 32'hffff_f800);
        ld_vector(F3_LBU, 12'h010, 5'd22, 5'd4, ALU_LBU, 32'h0000_0010);
        ld_vector(F3_LHU, 12'h123, 5'd23, 5'd5, ALU_LHU, 32'h0000_0123);
        st_vector(F3_SB, 12'hff8, 5'd6, 5'd7, ALU_SB, 32'hffff_fff8);
        st_vector(F3_SH, 12'h7ff, 5'd1, 5'd2, ALU_SH, 32'h0000_07ff);
        st_vector(F3_SW, 12'h804, 5'd3, 5'd4, ALU_SW, 32'hffff_f804);
        fwd_vector(5'd24, 5'd1, fwd_hit(1'b0, 5'd1, 32'h1111_1111),
                   fwd_hit(1'b0, 5'd1, 32'h2222_2222), lit_val(32'h1111_1111));
        fwd_vector(5'd25, 5'd1, fwd_hit(1'b0, 5'd9, 32'h5a5a_5a5a),
                   fwd_hit(1'b0, 5'd1, 32'h3333_3333), lit_val(32'h3333_3333));
        fwd_vector(5'd26, 5'd0, fwd_hit(1'b0, 5'd0, 32'h4444_4444),
                   fwd_hit(1'b0, 5'd0, 32'h5555_5555), lit_val(32'h0));
        // Load-use on rs1, then on rs2, each followed by the released retry
        bubble_vector(r_word(F7_BASE, F3_ADD_SUB, 5'd10, 5'd3, 5'd4), 1'b1,
                      fwd_hit(1'b1, 5'd3, 32'hdead_beef), 1'b1);
        rr_vector(F7_BASE, F3_ADD_SUB, 5'd10, 5'd3, 5'd4, ALU_ADD, RES_ARITH);
        bubble_vector(r_word(F7_ALT, F3_ADD_SUB, 5'd11, 5'd5, 5'd6), 1'b1,
                      fwd_hit(1'b1, 5'd6, 32'hdead_beef), 1'b1);
        rr_vector(F7_ALT, F3_ADD_SUB, 5'd11, 5'd5, 5'd6, ALU_SUB, RES_ARITH);
        push_vector(i_word(OPC_OP_IMM, F3_ADD_SUB, 12'h005, 5'd12, 5'd7), 1'b1,
                    fwd_hit(1'b1, 5'd5, 32'hdead_beef), NO_FWD, 1'b0, 1'b1, ALU_ADD,
                    RES_ARITH, 5'd12, 1'b1, reg_ref(5'd7), lit_val(32'h5), 32'h5);
        bubble_vector(r_word(F7_BASE, F3_ADD_SUB, 5'd8, 5'd1, 5'd2), 1'b0, NO_FWD, 1'b0);
        plain_vector({7'h00, 5'd2, 5'd1, 3'b000, 5'd9, 7'h7f}, ALU_NOP, RES_NOP, 5'd0, 1'b0,
                     lit_val(32'h0), lit_val(32'h0), 32'h0); // Unknown opcode
    endtask

    task automatic check_reset_state();
        expect_eq("id_ex.valid", 1'b0, id_ex.valid);
        expect_eq("id_ex.rd_we", 1'b0, id_ex.rd_we);
        expect_eq("stall", 1'b0, stall);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            $display("Timeout: reset still asserted after %0d cycles", TIMEOUT);
            stop_run();
        end
    endtask

    task automatic preload_regs();
        for (int r = 0; r < `REG_COUNT; r++) begin
            model[r] = '0;
        end
        for (int r = 1; r < 8; r++) begin
            @(negedge clk);
            model[r] = $random(seed);
            wb.we    = 1'b1;
            wb.addr  = r[4:0];
            wb.data  = model[r];
        end
        @(negedge clk);
        wb = '0;
    endtask

    task automatic run_vector(input int n, input vec_t t);
        row_idx = n;
        @(negedge clk);
        in_valid = t.in_valid;
        inst     = t.inst;
        ex_fwd   = t.ex;
        mem_fwd  = t.mem;
        #1;
        expect_eq("stall", t.stall, stall);
        @(posedge clk);
        #1;
        expect_eq("id_ex.valid", t.valid, id_ex.valid);
        expect_eq("id_ex.rd_we", t.rd_we, id_ex.rd_we);
        expect_eq("id_ex.alu_op", t.alu_op, id_ex.alu_op);
        if (t.valid) begin // Bubbles leave the data fields stale
            expect_eq("id_ex.res_sel", t.res_sel, id_ex.res_sel);
            expect_eq("id_ex.rd", t.rd, id_ex.rd);
            expect_eq("id_ex.op_a", resolve_operand(t.op_a), id_ex.op_a);
            expect_eq("id_ex.op_b", resolve_operand(t.op_b), id_ex.op_b);
            expect_eq("id_ex.imm", t.imm, id_ex.imm);
        end
    endtask

    initial begin
        seed     = 32'he515_a0b1;
        row_idx  = -1;
        in_valid = 1'b0;
        inst     = '0;
        ex_fwd   = '0;
        mem_fwd  = '0;
        wb       = '0;
        repeat (4) @(negedge clk);
        check_reset_state(); // Still inside reset
        wait_reset_release();
        @(negedge clk);
        check_reset_state();
        preload_regs();
        build_table();
        foreach (vecs[i]) begin
            run_vector(i, vecs[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/reg_file.sv
logic/id_ex_reg.sv
logic/id_stage.sv
bench/tb_id_stage.sv
